/* rtl/upsampler_defs.svh */
`ifndef UPSAMPLER_DEFS_SVH
`define UPSAMPLER_DEFS_SVH

// Width of each incoming I or Q sample
`define UPS_IW 16

// Width of one filter coefficient
`define UPS_CW 12

// Width of each outgoing I or Q result
`define UPS_OW 24

// Number of output samples produced for every accepted input sample
`define UPS_NUP 4

// Taps used by each polyphase branch
`define UPS_TAPS 8

// Total coefficient count, always NUP times TAPS
`define UPS_NCOEFFS 32

// Extra left shift applied ahead of rounding to gain some headroom
`define UPS_SHIFT 2

`endif

/* rtl/sample_pkg.sv */
`include "upsampler_defs.svh"

package sample_pkg;

	// One I or Q input sample
	typedef logic signed [`UPS_IW-1:0] sample_t;

	// One filter coefficient, shared by both channels
	typedef logic signed [`UPS_CW-1:0] coeff_t;

	// Full precision product of a sample and a coefficient
	typedef logic signed [`UPS_IW+`UPS_CW-1:0] product_t;

	// Accumulator keeps enough guard bits to sum every coefficient
	// of the filter without wrapping
	typedef logic signed [`UPS_IW+`UPS_CW+$clog2(`UPS_NCOEFFS)-1:0] acc_t;

	// Rounded and saturated output sample
	typedef logic signed [`UPS_OW-1:0] result_t;

endpackage

/* rtl/ctrl_pkg.sv */
`include "upsampler_defs.svh"

package ctrl_pkg;

	// The sequencer is either waiting for a sample or walking the taps
	typedef enum logic {SEQ_IDLE, SEQ_RUN} seq_state_e;

	// Index into coefficient memory
	typedef logic [$clog2(`UPS_NCOEFFS)-1:0] coeff_addr_t;

	// Tap offset behind the newest sample in the history
	typedef logic [$clog2(`UPS_TAPS)-1:0] tap_t;

	// Output phase within one input sample period
	typedef logic [$clog2(`UPS_NUP)-1:0] phase_t;

endpackage

/* rtl/coeff_bank.sv */
`timescale 1ns/1ns
`include "upsampler_defs.svh"

module coeff_bank (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_wr_coeff,
	input  sample_pkg::coeff_t    i_coeff,
	input  ctrl_pkg::coeff_addr_t i_addr,
	output sample_pkg::coeff_t    o_coeff
);

	// Coefficient storage, one entry per tap of the full prototype filter
	sample_pkg::coeff_t coeff_mem [`UPS_NCOEFFS];

	// Next location to be written by the load strobe
	ctrl_pkg::coeff_addr_t wr_ptr;

	////////////////////
	// Load side
	////////////////////

	// The pointer is as wide as the memory is deep, so it wraps back to
	// entry zero on its own once every coefficient has been written
	always_ff @(posedge i_clk)
		if (i_reset)
			wr_ptr <= '0;
		else if (i_wr_coeff)
			wr_ptr <= wr_ptr + 1'b1;

	always_ff @(posedge i_clk)
		if (i_wr_coeff)
			coeff_mem[wr_ptr] <= i_coeff;

	////////////////////
	// Read side
	////////////////////

	// Registered read so the coefficient lines up with the history output
	always_ff @(posedge i_clk)
		o_coeff <= coeff_mem[i_addr];

endmodule

/* rtl/sample_history.sv */
`timescale 1ns/1ns
`include "upsampler_defs.svh"

module sample_history (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_push,
	input  sample_pkg::sample_t i_sample_i,
	input  sample_pkg::sample_t i_sample_q,
	input  ctrl_pkg::tap_t      i_tap,
	output sample_pkg::sample_t o_data_i,
	output sample_pkg::sample_t o_data_q
);

	// One circular buffer per channel, as deep as one polyphase branch
	sample_pkg::sample_t hist_i [`UPS_TAPS];
	sample_pkg::sample_t hist_q [`UPS_TAPS];

	// Slot that the next accepted sample will occupy
	ctrl_pkg::tap_t wr_ptr;

	// Buffer slot of the requested tap
	ctrl_pkg::tap_t rd_addr;

	////////////////////
	// Write side
	////////////////////

	// Both channels share one pointer since they are always pushed together
	always_ff @(posedge i_clk)
		if (i_reset)
			wr_ptr <= '0;
		else if (i_push)
			wr_ptr <= wr_ptr + 1'b1;

	always_ff @(posedge i_clk)
		if (i_push)
		begin
			hist_i[wr_ptr] <= i_sample_i;
			hist_q[wr_ptr] <= i_sample_q;
		end

	////////////////////
	// Read side
	////////////////////

	// The newest sample sits one slot behind the write pointer and tap j
	// goes j further back, wrapping around the buffer
	assign rd_addr = wr_ptr - ctrl_pkg::tap_t'(1) - i_tap;

	always_ff @(posedge i_clk)
	begin
		o_data_i <= hist_i[rd_addr];
		o_data_q <= hist_q[rd_addr];
	end

endmodule

/* rtl/phase_sequencer.sv */
`timescale 1ns/1ns
`include "upsampler_defs.svh"

module phase_sequencer (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_valid,
	output logic                  o_ready,
	output logic                  o_push,
	output ctrl_pkg::tap_t        o_tap,
	output ctrl_pkg::coeff_addr_t o_coeff_addr,
	output logic                  o_first,
	output logic                  o_last
);

	// Final count values of the two nested counters
	localparam ctrl_pkg::tap_t   LAST_TAP   = ctrl_pkg::tap_t'(`UPS_TAPS - 1);
	localparam ctrl_pkg::phase_t LAST_PHASE = ctrl_pkg::phase_t'(`UPS_NUP - 1);

	ctrl_pkg::seq_state_e state;

	// Phase is the outer loop and tap the inner one
	ctrl_pkg::phase_t phase_cnt;
	ctrl_pkg::tap_t   tap_cnt;

	logic running;
	logic tap_end;
	logic seq_end;

	////////////////////
	// Status decode
	////////////////////

	assign running = (state == ctrl_pkg::SEQ_RUN);

	// Last tap of the current phase
	assign tap_end = (tap_cnt == LAST_TAP);

	// Last tap of the last phase ends the whole sample period
	assign seq_end = tap_end && (phase_cnt == LAST_PHASE);

	// Only one sample is in flight at a time so we are ready while idle
	assign o_ready = !running;

	// This is the single place where the handshake is evaluated
	assign o_push = i_valid && o_ready;

	////////////////////
	// State machine
	////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			state     <= ctrl_pkg::SEQ_IDLE;
			phase_cnt <= '0;
			tap_cnt   <= '0;
		end
		else
		begin
			unique case (state)
				ctrl_pkg::SEQ_IDLE:
				begin
					// Start every sample period from phase 0 and tap 0
					if (o_push)
					begin
						state     <= ctrl_pkg::SEQ_RUN;
						phase_cnt <= '0;
						tap_cnt   <= '0;
					end
				end
				ctrl_pkg::SEQ_RUN:
				begin
					// One tap read per clock
					if (tap_end)
					begin
						tap_cnt   <= '0;
						phase_cnt <= phase_cnt + 1'b1;
					end
					else
						tap_cnt <= tap_cnt + 1'b1;

					// Go back to accepting samples after the final read
					if (seq_end)
						state <= ctrl_pkg::SEQ_IDLE;
				end
				default:
					state <= ctrl_pkg::SEQ_IDLE;
			endcase
		end

	////////////////////
	// Read addresses and strobes
	////////////////////

	assign o_tap = tap_cnt;

	// Coefficient index is tap*NUP+phase, and with NUP a power of two
	// that is just the tap count above the phase count
	assign o_coeff_addr = {tap_cnt, phase_cnt};

	// The MAC loads on the first tap and hands off its sum on the last
	assign o_first = running && (tap_cnt == '0);
	assign o_last  = running && tap_end;

endmodule

/* rtl/mac_iq.sv */
`timescale 1ns/1ns

module mac_iq (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_first,
	input  logic                i_last,
	input  sample_pkg::sample_t i_data_i,
	input  sample_pkg::sample_t i_data_q,
	input  sample_pkg::coeff_t  i_coeff,
	output sample_pkg::acc_t    o_acc_i,
	output sample_pkg::acc_t    o_acc_q,
	output logic                o_done
);

	// Strobes aligned with the read data and then with the products
	logic first_d;
	logic last_d;
	logic first_p;
	logic last_p;

	sample_pkg::product_t prod_i;
	sample_pkg::product_t prod_q;

	////////////////////
	// Strobe pipeline
	////////////////////

	// The memories take one cycle to answer the sequencer, and the
	// multiplier another, so the strobes ride along two stages
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			first_d <= 1'b0;
			last_d  <= 1'b0;
			first_p <= 1'b0;
			last_p  <= 1'b0;
			o_done  <= 1'b0;
		end
		else
		begin
			first_d <= i_first;
			last_d  <= i_last;
			first_p <= first_d;
			last_p  <= last_d;
			// The sum is complete on the cycle after the last product
			o_done  <= last_p;
		end

	////////////////////
	// Multiply and accumulate
	////////////////////

	// Both channels share the same coefficient on every clock
	always_ff @(posedge i_clk)
	begin
		prod_i <= i_data_i * i_coeff;
		prod_q <= i_data_q * i_coeff;
	end

	// A first product starts a new sum and anything else adds to it
	always_ff @(posedge i_clk)
		if (first_p)
		begin
			o_acc_i <= sample_pkg::acc_t'(prod_i);
			o_acc_q <= sample_pkg::acc_t'(prod_q);
		end
		else
		begin
			o_acc_i <= o_acc_i + sample_pkg::acc_t'(prod_i);
			o_acc_q <= o_acc_q + sample_pkg::acc_t'(prod_q);
		end

endmodule

/* rtl/round_saturate.sv */
`timescale 1ns/1ns
`include "upsampler_defs.svh"

module round_saturate (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_done,
	input  sample_pkg::acc_t    i_acc_i,
	input  sample_pkg::acc_t    i_acc_q,
	output logic                o_ce,
	output sample_pkg::result_t o_result_i,
	output sample_pkg::result_t o_result_q
);

	localparam int ACC_W = $bits(sample_pkg::acc_t);
	localparam int OW    = `UPS_OW;

	// Bits dropped below the output LSB once the pre-shift is applied
	localparam int DROP  = ACC_W - OW - `UPS_SHIFT;

	// Half an output LSB, on one guard bit above the accumulator
	localparam logic signed [ACC_W:0] HALF =
		{{(ACC_W-DROP+1){1'b0}}, 1'b1, {(DROP-1){1'b0}}};

	localparam sample_pkg::result_t RES_MAX = {1'b0, {(OW-1){1'b1}}};
	localparam sample_pkg::result_t RES_MIN = {1'b1, {(OW-1){1'b0}}};

	// Round half up, drop the low bits and clamp to the output range
	function automatic sample_pkg::result_t round_sat(input sample_pkg::acc_t acc);
		logic signed [ACC_W:0]      sum;
		logic signed [ACC_W-DROP:0] scaled;
		sum    = {acc[ACC_W-1], acc} + HALF;
		scaled = sum[ACC_W:DROP];
		// The value fits when every bit above the output sign agrees with it
		if ((&scaled[ACC_W-DROP:OW-1]) || !(|scaled[ACC_W-DROP:OW-1]))
			return scaled[OW-1:0];
		// Clamp towards the side the accumulator was on
		return acc[ACC_W-1] ? RES_MIN : RES_MAX;
	endfunction

	always_ff @(posedge i_clk)
		if (i_reset)
			o_ce <= 1'b0;
		else
			o_ce <= i_done;

	// Results only move with o_ce and hold otherwise
	always_ff @(posedge i_clk)
		if (i_done)
		begin
			o_result_i <= round_sat(i_acc_i);
			o_result_q <= round_sat(i_acc_q);
		end

endmodule

/* rtl/pulse_shaper_iq.sv */
`timescale 1ns/1ns

module pulse_shaper_iq (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_wr_coeff,
	input  sample_pkg::coeff_t  i_coeff,
	input  logic                i_valid,
	output logic                o_ready,
	input  sample_pkg::sample_t i_sample_i,
	input  sample_pkg::sample_t i_sample_q,
	output logic                o_ce,
	output sample_pkg::result_t o_result_i,
	output sample_pkg::result_t o_result_q
);

	////////////////////
	// Interconnect
	////////////////////

	// Sequencer to memories and MAC
	logic                  push;
	ctrl_pkg::tap_t        tap;
	ctrl_pkg::coeff_addr_t coeff_addr;
	logic                  first;
	logic                  last;

	// Memory read data into the MAC
	sample_pkg::coeff_t  coeff;
	sample_pkg::sample_t data_i;
	sample_pkg::sample_t data_q;

	// Finished sums into the output stage
	sample_pkg::acc_t acc_i;
	sample_pkg::acc_t acc_q;
	logic             done;

	phase_sequencer u_phase_sequencer (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_valid      (i_valid),
		.o_ready      (o_ready),
		.o_push       (push),
		.o_tap        (tap),
		.o_coeff_addr (coeff_addr),
		.o_first      (first),
		.o_last       (last)
	);

	coeff_bank u_coeff_bank (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wr_coeff (i_wr_coeff),
		.i_coeff    (i_coeff),
		.i_addr     (coeff_addr),
		.o_coeff    (coeff)
	);

	sample_history u_sample_history (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_push     (push),
		.i_sample_i (i_sample_i),
		.i_sample_q (i_sample_q),
		.i_tap      (tap),
		.o_data_i   (data_i),
		.o_data_q   (data_q)
	);

	mac_iq u_mac_iq (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_first  (first),
		.i_last   (last),
		.i_data_i (data_i),
		.i_data_q (data_q),
		.i_coeff  (coeff),
		.o_acc_i  (acc_i),
		.o_acc_q  (acc_q),
		.o_done   (done)
	);

	round_saturate u_round_saturate (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_done     (done),
		.i_acc_i    (acc_i),
		.i_acc_q    (acc_q),
		.o_ce       (o_ce),
		.o_result_i (o_result_i),
		.o_result_q (o_result_q)
	);

endmodule

/* sim/tb_pulse_shaper_iq.sv */
`timescale 1ns/1ns
`include "upsampler_defs.svh"

module tb_pulse_shaper_iq;

	typedef enum {K_LOAD, K_POKE, K_PUSH, K_RESET} row_kind_e;

	// For load rows si picks the coefficient set, for poke rows it is the write count
	typedef struct {
		int                  test;
		row_kind_e           kind;
		sample_pkg::sample_t si;
		sample_pkg::sample_t sq;
		bit                  sat;
	} row_t;

	// One expected output pair, checked only once the model history is fully known
	typedef struct {
		sample_pkg::result_t ri;
		sample_pkg::result_t rq;
		bit                  known;
	} expect_t;

	localparam int NTESTS = 6;
	localparam int AW     = $bits(sample_pkg::acc_t);
	localparam int DROP   = AW - `UPS_OW - `UPS_SHIFT;

	logic                i_clk;
	logic                i_reset;
	logic                i_wr_coeff;
	sample_pkg::coeff_t  i_coeff;
	logic                i_valid;
	logic                o_ready;
	sample_pkg::sample_t i_sample_i;
	sample_pkg::sample_t i_sample_q;
	logic                o_ce;
	sample_pkg::result_t o_result_i;
	sample_pkg::result_t o_result_q;

	row_t                rows [$];
	expect_t             exp_q [$];
	sample_pkg::coeff_t  model_coeff [`UPS_NCOEFFS];
	sample_pkg::sample_t hist_i [`UPS_TAPS];
	sample_pkg::sample_t hist_q [`UPS_TAPS];
	bit                  hist_known [`UPS_TAPS];
	string               test_name [1:NTESTS];
	logic [31:0]         rng_state;
	int model_ptr;
	int errors;
	int err_base;
	int checks;
	int got_ce;
	int want_ce;
	int clamp_hits;
	int tests_failed;
	int cycles;
	int cycle_limit;

	pulse_shaper_iq i_pulse_shaper_iq (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wr_coeff (i_wr_coeff),
		.i_coeff    (i_coeff),
		.i_valid    (i_valid),
		.o_ready    (o_ready),
		.i_sample_i (i_sample_i),
		.i_sample_q (i_sample_q),
		.o_ce       (o_ce),
		.o_result_i (o_result_i),
		.o_result_q (o_result_q)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// Hard stop so that a stuck handshake cannot hang the run
	always @(posedge i_clk)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////
	// Reference model
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Set 0 and 4 are ramps of opposite slope, 1 and 2 the full-scale extremes
	function automatic sample_pkg::coeff_t coeff_of(input int set, input int k);
		case (set)
			0: return sample_pkg::coeff_t'(64 * k - 1000);
			1: return sample_pkg::coeff_t'(2047);
			2: return sample_pkg::coeff_t'(-2048);
			3: return sample_pkg::coeff_t'(next_rand() >> 20);
			default: return sample_pkg::coeff_t'(1500 - 90 * k);
		endcase
	endfunction

	// Divide by 2^DROP with half an LSB added first, then clamp to the output range
	function automatic sample_pkg::result_t round_ref(input longint acc, output bit clamped);
		longint r;
		longint lim;
		lim     = longint'(1) <<< (`UPS_OW - 1);
		r       = (acc + (longint'(1) <<< (DROP - 1))) >>> DROP;
		clamped = 1'b0;
		if (r > lim - 1)
		begin
			r       = lim - 1;
			clamped = 1'b1;
		end
		else if (r < -lim)
		begin
			r       = -lim;
			clamped = 1'b1;
		end
		return sample_pkg::result_t'(r);
	endfunction

	// Shift a new sample into the history and queue one output per phase
	task automatic model_push(input sample_pkg::sample_t xi, input sample_pkg::sample_t xq,
		input bit sat);
		longint  acc_i;
		longint  acc_q;
		bit      all_known;
		bit      ci;
		bit      cq;
		int      j;
		int      p;
		expect_t e;
		for (j = `UPS_TAPS - 1; j > 0; j--)
		begin
			hist_i[j]     = hist_i[j-1];
			hist_q[j]     = hist_q[j-1];
			hist_known[j] = hist_known[j-1];
		end
		hist_i[0]     = xi;
		hist_q[0]     = xq;
		hist_known[0] = 1'b1;
		all_known = 1'b1;
		for (j = 0; j < `UPS_TAPS; j++)
			all_known = all_known & hist_known[j];
		for (p = 0; p < `UPS_NUP; p++)
		begin
			acc_i = 0;
			acc_q = 0;
			// Phase p uses every NUP-th coefficient starting at p
			for (j = 0; j < `UPS_TAPS; j++)
			begin
				acc_i += longint'(hist_i[j]) * longint'(model_coeff[j*`UPS_NUP+p]);
				acc_q += longint'(hist_q[j]) * longint'(model_coeff[j*`UPS_NUP+p]);
			end
			e.ri    = round_ref(acc_i, ci);
			e.rq    = round_ref(acc_q, cq);
			e.known = all_known;
			if (sat && (ci || cq))
				clamp_hits++;
			exp_q.push_back(e);
		end
		want_ce += `UPS_NUP;
	endtask

	////////////////////
	// Checks
	////////////////////

	task automatic check_result(input string name, input sample_pkg::result_t got,
		input sample_pkg::result_t want);
		checks++;
		if (got !== want)
		begin
			$display("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int want);
		checks++;
		if (got != want)
		begin
			$display("Missing or extra o_ce pulses in %s: %0d seen where %0d were due",
				name, got, want);
			errors++;
		end
	endtask

	// Every o_ce takes the oldest expected pair off the queue
	always @(negedge i_clk)
	begin : watch_outputs
		expect_t e;
		if (o_ce === 1'b1)
		begin
			got_ce = got_ce + 1;
			if (exp_q.size() == 0)
			begin
				$display("An o_ce pulse at %0t ns came with no output pending", $time);
				errors++;
			end
			else
			begin
				e = exp_q.pop_front();
				if (e.known)
				begin
					check_result("o_result_i", o_result_i, e.ri);
					check_result("o_result_q", o_result_q, e.rq);
				end
			end
		end
	end

	////////////////////
	// Drivers
	////////////////////

	// All driving happens right after a falling edge
	task automatic write_coeff(input sample_pkg::coeff_t c);
		i_wr_coeff             = 1'b1;
		i_coeff                = c;
		model_coeff[model_ptr] = c;
		model_ptr              = (model_ptr + 1) % `UPS_NCOEFFS;
		@(negedge i_clk);
	endtask

	task automatic wait_idle();
		while (o_ready !== 1'b1)
			@(negedge i_clk);
	endtask

	task automatic load_coeffs(input int set, input int count);
		int k;
		wait_idle();
		for (k = 0; k < count; k++)
			write_coeff(coeff_of(set, k));
		i_wr_coeff = 1'b0;
	endtask

	// Holds i_valid until a rising edge sees o_ready, which is stable at the falling edge
	task automatic push_sample(input row_t r);
		bit taken;
		i_valid    = 1'b1;
		i_sample_i = r.si;
		i_sample_q = r.sq;
		taken      = 1'b0;
		while (!taken)
		begin
			taken = (o_ready === 1'b1);
			@(negedge i_clk);
		end
		i_valid = 1'b0;
		model_push(r.si, r.sq, r.sat);
	endtask

	// Outputs still in flight are lost and the history content becomes unknown
	task automatic apply_reset();
		int k;
		i_reset    = 1'b1;
		i_valid    = 1'b0;
		i_wr_coeff = 1'b0;
		repeat (4) @(negedge i_clk);
		i_reset = 1'b0;
		want_ce -= exp_q.size();
		exp_q.delete();
		for (k = 0; k < `UPS_TAPS; k++)
			hist_known[k] = 1'b0;
		model_ptr = 0;
		checks++;
		if (o_ce !== 1'b0 || o_ready !== 1'b1)
		begin
			$display("After reset at %0t ns o_ce was not low or o_ready was not high", $time);
			errors++;
		end
	endtask

	////////////////////
	// Stimulus table
	////////////////////

	task automatic add_row(input int test, input row_kind_e kind, input int si, input int sq,
		input bit sat);
		row_t r;
		r.test = test;
		r.kind = kind;
		r.si   = sample_pkg::sample_t'(si);
		r.sq   = sample_pkg::sample_t'(sq);
		r.sat  = sat;
		rows.push_back(r);
	endtask

	task automatic build_table();
		int          k;
		logic [31:0] r;
		// Ramp, priming zeros, then an impulse that walks through all 32 coefficients
		add_row(1, K_LOAD, 0, 0, 0);
		repeat (`UPS_TAPS) add_row(1, K_PUSH, 0, 0, 0);
		add_row(1, K_PUSH, 16384, -16384, 0);
		repeat (`UPS_TAPS) add_row(1, K_PUSH, 0, 0, 0);
		// Back to back pushes so that each one waits while o_ready is low
		for (k = 0; k < 6; k++)
			add_row(2, K_PUSH, 1000 * k - 2500, 700 - 300 * k, 0);
		for (k = 0; k < 8; k++)
			add_row(3, K_PUSH, 4000 * k - 14000, (k % 2 == 1) ? -9000 : 12000 - 500 * k, 0);
		// Full-scale data against both coefficient extremes
		add_row(4, K_LOAD, 1, 0, 0);
		repeat (`UPS_TAPS) add_row(4, K_PUSH, 32767, -32768, 1);
		add_row(4, K_LOAD, 2, 0, 0);
		repeat (`UPS_TAPS) add_row(4, K_PUSH, -32768, 32767, 1);
		add_row(5, K_LOAD, 3, 0, 0);
		for (k = 0; k < 30; k++)
		begin
			r = next_rand();
			add_row(5, K_PUSH, int'(r[15:0]), int'(r[31:16]), 0);
		end
		// Stray writes move the pointer, then a reset mid-run must bring it back to zero
		add_row(6, K_POKE, 5, 0, 0);
		add_row(6, K_PUSH, 5000, -5000, 0);
		add_row(6, K_PUSH, -7000, 3000, 0);
		add_row(6, K_RESET, 0, 0, 0);
		add_row(6, K_LOAD, 4, 0, 0);
		repeat (`UPS_TAPS) add_row(6, K_PUSH, 0, 0, 0);
		for (k = 0; k < 6; k++)
			add_row(6, K_PUSH, 9000 - 3100 * k, 2000 * k - 6000, 0);
	endtask

	task automatic start_test();
		got_ce     = 0;
		want_ce    = 0;
		clamp_hits = 0;
		err_base   = errors;
	endtask

	// Drain the queue and leave a few quiet cycles to catch stray pulses
	task automatic finish_test(input int t);
		while (exp_q.size() != 0)
			@(negedge i_clk);
		repeat (8) @(negedge i_clk);
		check_count(test_name[t], got_ce, want_ce);
		if (errors != err_base)
			tests_failed++;
		$display("Test %0d %s: %s, %0d o_ce pulses, %0d clamped", t, test_name[t],
			(errors == err_base) ? "ok" : "mismatches found", got_ce, clamp_hits);
	endtask

	initial
	begin
		int idx;
		int cur;
		i_reset      = 1'b1;
		i_wr_coeff   = 1'b0;
		i_coeff      = '0;
		i_valid      = 1'b0;
		i_sample_i   = '0;
		i_sample_q   = '0;
		rng_state    = 32'hbb95;
		model_ptr    = 0;
		errors       = 0;
		checks       = 0;
		tests_failed = 0;
		cycles       = 0;
		test_name[1] = "impulse response";
		test_name[2] = "upsample count and back-pressure";
		test_name[3] = "I/Q independence";
		test_name[4] = "saturation";
		test_name[5] = "random data";
		test_name[6] = "reset and reload";
		build_table();
		cycle_limit = rows.size() * 40 + 200;
		start_test();
		apply_reset();
		cur = rows[0].test;
		for (idx = 0; idx < rows.size(); idx++)
		begin
			if (rows[idx].test != cur)
			begin
				finish_test(cur);
				cur = rows[idx].test;
				start_test();
			end
			case (rows[idx].kind)
				K_LOAD:  load_coeffs(int'(rows[idx].si), `UPS_NCOEFFS);
				K_POKE:  load_coeffs(3, int'(rows[idx].si));
				K_PUSH:  push_sample(rows[idx]);
				default: apply_reset();
			endcase
		end
		finish_test(cur);
		$display("Tests %0d, failed %0d, checks %0d, errors %0d", NTESTS, tests_failed,
			checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+rtl
rtl/sample_pkg.sv
rtl/ctrl_pkg.sv
rtl/coeff_bank.sv
rtl/sample_history.sv
rtl/phase_sequencer.sv
rtl/mac_iq.sv
rtl/round_saturate.sv
rtl/pulse_shaper_iq.sv
sim/tb_pulse_shaper_iq.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pulse_shaper_iq
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
